//--- dcache.f
hw/dcache_pkg.sv
hw/dcache_bank.sv
hw/dcache_ctrl.sv
hw/dcache_wb_master.sv
hw/dcache_top.sv
tests/wb_mem_model.sv
tests/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the dcache testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f dcache.f -o sim_dcache > build.log 2>&1 \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || { echo "Build or run did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

! grep -q "Result: FAILED" sim.log \
    && grep -q "Result: PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int CLK_HALF     = 2;
    localparam int RST_CYCLES   = 16;
    localparam int N_RANDOM     = 2000;
    localparam int N_DIRECTED   = 9;
    // Dirty read miss with the slowest ack on both bus accesses and some slack
    localparam int WORST_CYCLES = 30;
    localparam int TIMEOUT_NS   =
        (N_RANDOM + N_DIRECTED + RST_CYCLES) * WORST_CYCLES * 2 * CLK_HALF * 2;

    logic              clk = 1'b0;
    logic              rst;
    cpu_req_t          cpu_req;
    logic              stall;
    logic [31:0]       rdata;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [31:0]       wb_dat_w;
    logic [31:0]       wb_dat_r;
    logic [3:0]        wb_sel;
    logic              wb_ack;
    logic [31:0]       rd_count;
    logic [31:0]       wr_count;

    integer            seed = 32'h0dd8_3ca3;
    int                errors = 0;
    int                checks = 0;
    int                evictions = 0;
    logic              cyc_prev = 1'b0;
    logic              ack_prev = 1'b0;

    // Memory as the core sees it and a shadow of the line state
    logic [31:0]       ref_mem [1<<ADDR_W];
    logic [LINES-1:0]  sh_valid;
    logic [LINES-1:0]  sh_dirty;
    logic [TAG_W-1:0]  sh_tag [LINES];

    always #(CLK_HALF) clk = ~clk;

    dcache_top u_dut (
        .clk_i     (clk),
        .rst_i     (rst),
        .cpu_req_i (cpu_req),
        .stall_o   (stall),
        .rdata_o   (rdata),
        .wb_cyc_o  (wb_cyc),
        .wb_stb_o  (wb_stb),
        .wb_we_o   (wb_we),
        .wb_adr_o  (wb_adr),
        .wb_dat_o  (wb_dat_w),
        .wb_sel_o  (wb_sel),
        .wb_dat_i  (wb_dat_r),
        .wb_ack_i  (wb_ack)
    );

    wb_mem_model u_mem (
        .clk_i      (clk),
        .rst_i      (rst),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_sel_i   (wb_sel),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack),
        .rd_count_o (rd_count),
        .wr_count_o (wr_count)
    );

    function automatic logic [31:0] line_pattern(input logic [31:0] a);
        line_pattern = (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    // Reads, full words, single bytes and halves
    function automatic logic [3:0] pick_mask(input logic [3:0] r);
        case (r[2:0])
            3'd0, 3'd1: pick_mask = 4'b0000;
            3'd2:       pick_mask = 4'b1111;
            3'd7:       pick_mask = r[3] ? 4'b1100 : 4'b0011;
            default:    pick_mask = 4'b0001 << (r[2:0] - 3'd3);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic run_request(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [3:0] mask, input logic [31:0] wdata);
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             hit;
        logic             evict;
        logic [31:0]      exp_rd;
        logic [31:0]      rd0;
        logic [31:0]      wr0;
        data_word_u       old_word;
        data_word_u       new_word;
        tag   = addr[ADDR_W-1 -: TAG_W];
        idx   = addr[IDX_W-1:0];
        hit   = sh_valid[idx] && (sh_tag[idx] == tag);
        evict = sh_valid[idx] && sh_dirty[idx] && !hit;
        // Reads fetch on a miss and partial writes unless the line is a dirty hit
        if (mask == 4'b0000) begin
            exp_rd = {31'd0, !hit};
        end else if (mask == 4'b1111) begin
            exp_rd = 32'd0;
        end else begin
            exp_rd = {31'd0, !(hit && sh_dirty[idx])};
        end
        rd0 = rd_count;
        wr0 = wr_count;
        cpu_req.sel   = 1'b1;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.mask  = mask;
        do begin
            @(negedge clk);
        end while (stall);
        if (mask == 4'b0000) begin
            check_value(name, ref_mem[addr], rdata);
        end
        check_value({name, " bus reads"}, exp_rd, rd_count - rd0);
        check_value({name, " bus writes"}, {31'd0, evict}, wr_count - wr0);
        old_word.word = ref_mem[addr];
        new_word.word = wdata;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                old_word.bytes[b] = new_word.bytes[b];
            end
        end
        ref_mem[addr] = old_word.word;
        if (evict) begin
            evictions++;
        end
        sh_dirty[idx] = (mask != 4'b0000) || (hit && sh_dirty[idx]);
        sh_valid[idx] = 1'b1;
        sh_tag[idx]   = tag;
        @(posedge clk);
        #1;
        cpu_req.sel = 1'b0;
    endtask

    // Once raised, cyc and stb stay high until the ack
    always @(negedge clk) begin
        if (!rst && cyc_prev && !ack_prev) begin
            check_value("wb_hold", 32'd3, {30'd0, wb_cyc, wb_stb});
        end
        if (!rst && wb_cyc) begin
            check_value("wb_sel", 32'hf, {28'd0, wb_sel});
        end
        cyc_prev <= wb_cyc;
        ack_prev <= wb_ack;
    end

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Timeout: the cache stopped answering before all requests were done");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0]       r;
        logic [31:0]       w;
        logic [ADDR_W-1:0] addr;
        rst      = 1'b1;
        cpu_req  = '0;
        sh_valid = '0;
        sh_dirty = '0;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            ref_mem[a]   = line_pattern(a);
            u_mem.mem[a] = line_pattern(a);
        end
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("stall_after_reset", 32'd0, {31'd0, stall});
        @(posedge clk);
        #1;

        run_request("read_after_reset", {8'h12, 9'h034}, 4'b0000, 32'd0);
        run_request("read_hit", {8'h12, 9'h034}, 4'b0000, 32'd0);
        run_request("full_write", {8'h20, 9'h100}, 4'b1111, 32'hcafe_f00d);
        run_request("full_write_read", {8'h20, 9'h100}, 4'b0000, 32'd0);
        run_request("byte_write", {8'h33, 9'h0a5}, 4'b0010, 32'h0000_ab00);
        run_request("byte_merge_read", {8'h33, 9'h0a5}, 4'b0000, 32'd0);
        run_request("half_write", {8'h34, 9'h0a5}, 4'b1100, 32'h1234_0000);
        run_request("half_merge_read", {8'h34, 9'h0a5}, 4'b0000, 32'd0);
        run_request("dirty_evict", {8'h21, 9'h100}, 4'b0000, 32'd0);
        check_value("evict_writeback", 32'hcafe_f00d, u_mem.mem[{8'h20, 9'h100}]);

        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            w = $random(seed);
            // Four tags over sixteen lines keep conflicts frequent
            addr = {6'b1010_01, r[1:0], 5'd0, r[5:2]};
            run_request("random", addr, pick_mask(r[9:6]), w);
        end

        check_value("total_bus_writes", evictions, wr_count);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tests/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model
    import dcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]       wb_dat_i,
    input  logic [3:0]        wb_sel_i,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack_o,
    output logic [31:0]       rd_count_o,
    output logic [31:0]       wr_count_o
);

    // Backing store loaded by the testbench at time zero
    logic [31:0] mem [1<<ADDR_W];

    logic        busy_q;
    logic [2:0]  wait_q;
    logic [31:0] draw;
    integer      seed = 32'h0dd8_3ca3;

    // Registered ack after a random wait of 0 to 5 cycles
    always @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o   <= 1'b0;
            wb_dat_o   <= '0;
            busy_q     <= 1'b0;
            wait_q     <= '0;
            rd_count_o <= '0;
            wr_count_o <= '0;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;
        end else if (wb_cyc_i && wb_stb_i) begin
            if (!busy_q) begin
                draw = $random(seed);
                busy_q <= 1'b1;
                wait_q <= 3'(draw % 32'd6);
            end else if (wait_q != 3'd0) begin
                wait_q <= wait_q - 3'd1;
            end else begin
                busy_q   <= 1'b0;
                wb_ack_o <= 1'b1;
                if (wb_we_i) begin
                    // Only the selected byte lanes are stored
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel_i[b]) begin
                            mem[wb_adr_i][8*b +: 8] <= wb_dat_i[8*b +: 8];
                        end
                    end
                    wr_count_o <= wr_count_o + 32'd1;
                end else begin
                    wb_dat_o   <= mem[wb_adr_i];
                    rd_count_o <= rd_count_o + 32'd1;
                end
            end
        end
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  cpu_req_t          cpu_req_i,
    output logic              stall_o,
    output logic [31:0]       rdata_o,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [31:0]       wb_dat_o,
    output logic [3:0]        wb_sel_o,
    input  logic [31:0]       wb_dat_i,
    input  logic              wb_ack_i
);

    bank_wr_t [LANES-1:0]  bank_wr;
    logic [LANES-1:0][7:0] bank_rd;
    logic [IDX_W-1:0]      rd_idx;
    logic                  rd_en;
    mem_req_t              mem_req;
    mem_rsp_t              mem_rsp;

    dcache_ctrl u_ctrl (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .cpu_req_i (cpu_req_i),
        .stall_o   (stall_o),
        .rdata_o   (rdata_o),
        .bank_wr_o (bank_wr),
        .rd_idx_o  (rd_idx),
        .rd_en_o   (rd_en),
        .bank_rd_i (bank_rd),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    // Four data lanes and the tag lane
    for (genvar g = 0; g < LANES; g++) begin : g_bank
        dcache_bank u_bank (
            .clk_i     (clk_i),
            .wr_i      (bank_wr[g]),
            .rd_idx_i  (rd_idx),
            .rd_en_i   (rd_en),
            .rd_data_o (bank_rd[g])
        );
    end

    dcache_wb_master u_wb (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (mem_req),
        .rsp_o    (mem_rsp),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

endmodule

//--- hw/dcache_wb_master.sv
`timescale 1ns/1ps

module dcache_wb_master
    import dcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_req_t          req_i,
    output mem_rsp_t          rsp_o,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [31:0]       wb_dat_o,
    output logic [3:0]        wb_sel_o,
    input  logic [31:0]       wb_dat_i,
    input  logic              wb_ack_i
);

    logic              cyc_q;
    logic              stb_q;
    logic              we_q;
    logic [ADDR_W-1:0] adr_q;
    logic [31:0]       dat_q;

    logic              launch;
    logic              ack_seen;

    // One access at a time, a new one only while the bus is free
    assign launch   = req_i.valid && !cyc_q;
    assign ack_seen = cyc_q && stb_q && wb_ack_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
        end else if (launch) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
        end else if (ack_seen) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
        end
    end

    // Address and data stay put for the whole bus cycle
    always_ff @(posedge clk_i) begin
        if (launch) begin
            we_q  <= req_i.we;
            adr_q <= req_i.addr;
            dat_q <= req_i.wdata;
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = stb_q;
    assign wb_we_o  = we_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;
    assign wb_sel_o = 4'hf;

    assign rsp_o.done  = ack_seen;
    assign rsp_o.rdata = wb_dat_i;

    a_stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(wb_stb_o) |-> wb_cyc_o);

    // Controller keeps its request steady while the cycle is open
    a_req_held_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_cyc_o |-> req_i.valid && $stable(req_i));

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  cpu_req_t              cpu_req_i,
    output logic                  stall_o,
    output logic [31:0]           rdata_o,
    output bank_wr_t [LANES-1:0]  bank_wr_o,
    output logic [IDX_W-1:0]      rd_idx_o,
    output logic                  rd_en_o,
    input  logic [LANES-1:0][7:0] bank_rd_i,
    output mem_req_t              mem_req_o,
    input  mem_rsp_t              mem_rsp_i
);

    logic [2:0]       state_q;
    logic [2:0]       state_d;

    // Line status kept in flops
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    // Array write source, set once a fill word is saved
    logic             fill_sel_q;
    data_word_u       fill_q;

    // Word and tag read in compare, used as read result and victim
    data_word_u       line_q;
    logic [TAG_W-1:0] victim_tag_q;

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic             is_read;
    logic             is_full;
    logic             line_valid;
    logic             line_dirty;
    logic             tag_hit;
    data_word_u       cpu_word;
    data_word_u       rd_word;
    data_word_u       merged;
    data_word_u       wr_word;

    assign req_tag    = cpu_req_i.addr[ADDR_W-1 -: TAG_W];
    assign req_idx    = cpu_req_i.addr[IDX_W-1:0];
    assign is_read    = (cpu_req_i.mask == 4'b0000);
    assign is_full    = &cpu_req_i.mask;
    assign line_valid = valid_q[req_idx];
    assign line_dirty = dirty_q[req_idx];
    assign tag_hit    = (bank_rd_i[TAG_LANE] == req_tag);

    assign cpu_word.word = cpu_req_i.wdata;

    // Gather the data lanes back into one word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rd_word.bytes[b] = bank_rd_i[b];
        end
    end

    // Fetched word with the masked core bytes laid over it
    always_comb begin
        merged.word = mem_rsp_i.rdata;
        for (int b = 0; b < 4; b++) begin
            if (cpu_req_i.mask[b]) begin
                merged.bytes[b] = cpu_word.bytes[b];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cpu_req_i.sel) begin
                    if (line_valid && (is_read || line_dirty)) begin
                        state_d = ST_CMP;
                    end else if (is_full) begin
                        state_d = ST_AWR;
                    end else begin
                        state_d = ST_MRD;
                    end
                end
            end
            ST_CMP: begin
                if (tag_hit) begin
                    state_d = is_read ? ST_DONE : ST_AWR;
                end else if (line_dirty) begin
                    state_d = ST_MWR;
                end else begin
                    state_d = ST_MRD;
                end
            end
            ST_MWR: begin
                // Full words need no fetch after the write-back
                if (mem_rsp_i.done) begin
                    state_d = is_full ? ST_AWR : ST_MRD;
                end
            end
            ST_MRD: begin
                if (mem_rsp_i.done) begin
                    state_d = ST_AWR;
                end
            end
            ST_AWR: begin
                // Reads go back through compare to pick up the new line
                state_d = is_read ? ST_CMP : ST_DONE;
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            valid_q    <= '0;
            dirty_q    <= '0;
            fill_sel_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                fill_sel_q <= 1'b0;
            end
            if ((state_q == ST_MRD) && mem_rsp_i.done) begin
                fill_sel_q <= 1'b1;
            end
            if (state_q == ST_AWR) begin
                valid_q[req_idx] <= 1'b1;
                dirty_q[req_idx] <= !is_read;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_CMP) begin
            line_q       <= rd_word;
            victim_tag_q <= bank_rd_i[TAG_LANE];
        end
        if ((state_q == ST_MRD) && mem_rsp_i.done) begin
            fill_q <= merged;
        end
    end

    // Bank writes, the fill word goes to every lane
    always_comb begin
        wr_word = fill_sel_q ? fill_q : cpu_word;
        for (int l = 0; l < TAG_LANE; l++) begin
            bank_wr_o[l].en   = (state_q == ST_AWR) && (fill_sel_q || cpu_req_i.mask[l]);
            bank_wr_o[l].idx  = req_idx;
            bank_wr_o[l].data = wr_word.bytes[l];
        end
        bank_wr_o[TAG_LANE].en   = (state_q == ST_AWR);
        bank_wr_o[TAG_LANE].idx  = req_idx;
        bank_wr_o[TAG_LANE].data = req_tag;
    end

    assign rd_idx_o = req_idx;
    assign rd_en_o  = (state_d == ST_CMP);

    assign mem_req_o.valid = (state_q == ST_MWR) || (state_q == ST_MRD);
    assign mem_req_o.we    = (state_q == ST_MWR);
    assign mem_req_o.addr  = (state_q == ST_MWR) ? {victim_tag_q, req_idx} : cpu_req_i.addr;
    assign mem_req_o.wdata = line_q.word;

    assign stall_o = (state_d != ST_IDLE);
    assign rdata_o = line_q.word;

    // Reset leaves the FSM idle, so an idle core sees no stall
    a_stall_low_after_reset: assert property (@(posedge clk_i)
        $past(rst_i) && !cpu_req_i.sel |-> !stall_o);

    // Request fields are frozen until the bus side answers
    a_mem_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_o.valid && !mem_rsp_i.done |=> $stable(mem_req_o));

endmodule

//--- hw/dcache_bank.sv
`timescale 1ns/1ps

module dcache_bank
    import dcache_pkg::*;
(
    input  logic             clk_i,
    input  bank_wr_t         wr_i,
    input  logic [IDX_W-1:0] rd_idx_i,
    input  logic             rd_en_i,
    output logic [7:0]       rd_data_o
);

    logic [7:0] mem_q [LINES];

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem_q[wr_i.idx] <= wr_i.data;
        end
    end

    // Registered read
    // a write to the same index in the same cycle is passed through,
    // so the re-read after a fill sees the new line
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            if (wr_i.en && (wr_i.idx == rd_idx_i)) begin
                rd_data_o <= wr_i.data;
            end else begin
                rd_data_o <= mem_q[rd_idx_i];
            end
        end
    end

    // Index from the controller must be driven whenever it writes
    a_wr_idx_known: assert property (@(posedge clk_i)
        wr_i.en |-> !$isunknown(wr_i.idx));

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry, one 32-bit word per line
    localparam int ADDR_W   = 17;
    localparam int TAG_W    = 8;
    localparam int IDX_W    = 9;
    localparam int LINES    = 512;
    localparam int LANES    = 5;
    localparam int TAG_LANE = 4;

    // Controller state codes
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CMP  = 3'd1;
    localparam logic [2:0] ST_AWR  = 3'd2;
    localparam logic [2:0] ST_MRD  = 3'd3;
    localparam logic [2:0] ST_MWR  = 3'd4;
    localparam logic [2:0] ST_DONE = 3'd5;

    // Core request, a zero mask means read
    typedef struct packed {
        logic              sel;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        mask;
    } cpu_req_t;

    // One memory access, held until done
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } mem_rsp_t;

    // Write port of one byte-wide bank
    typedef struct packed {
        logic             en;
        logic [IDX_W-1:0] idx;
        logic [7:0]       data;
    } bank_wr_t;

    // Same word as a whole or split into byte lanes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } data_word_u;

endpackage
